// ==== hdl/bitops_op_pkg.sv ====
package bitops_op_pkg;

    ////////////////////////////////////////
    // opcodes
    ////////////////////////////////////////

    // two bits on the request bus
    typedef enum logic [1:0] {
        // two's-complement negate
        OP_NEG        = 2'd0,
        // keep only the rightmost set bit
        OP_ISO_ONE    = 2'd1,
        // log2 of a one-hot word
        OP_ONEHOT_IDX = 2'd2,
        // position of the lowest set bit
        OP_PRIO_IDX   = 2'd3
    } op_e;

    ////////////////////////////////////////
    // index width
    ////////////////////////////////////////

    // bits needed to name one position of a width-bit word
    // never below one bit
    function automatic int unsigned idx_width(input int unsigned width);
        int unsigned w;
        w = $clog2(width);
        return (w < 1) ? 1 : w;
    endfunction

endpackage: bitops_op_pkg

// ==== hdl/bitops_bus_pkg.sv ====
package bitops_bus_pkg;

    ////////////////////////////////////////
    // port widths
    ////////////////////////////////////////

    // operand and result width
    localparam int unsigned DATA_W = 32;

    ////////////////////////////////////////
    // request port payload
    ////////////////////////////////////////

    // op in the upper bits, operand below
    typedef struct packed {
        bitops_op_pkg::op_e op;
        logic [DATA_W-1:0]  operand;
    } req_t;

    ////////////////////////////////////////
    // response port payload
    ////////////////////////////////////////

    // index results come zero-extended in result
    // flag meaning depends on the opcode
    //   neg:        operand was the most negative value
    //   iso:        operand nonzero
    //   onehot idx: operand was one-hot
    //   prio idx:   some bit set
    typedef struct packed {
        logic [DATA_W-1:0] result;
        logic              flag;
    } rsp_t;

endpackage: bitops_bus_pkg

// ==== hdl/bit_isolate.sv ====
`timescale 1ns/1ps

module bit_isolate #(
    parameter int unsigned WIDTH = 32
)(
    // system signals
    input  logic                 clk,
    input  logic                 rst_i,
    // stage enable from the controller
    input  logic                 en_i,
    // operand
    input  logic [WIDTH-1:0]     operand_i,
    // registered results
    output bitops_bus_pkg::rsp_t neg_rsp_o,
    output bitops_bus_pkg::rsp_t iso_rsp_o
);

    ////////////////////////////////////////
    // local signals
    ////////////////////////////////////////

    localparam int unsigned DW = bitops_bus_pkg::DATA_W;
    // most negative value, only the sign bit set
    localparam logic [WIDTH-1:0] MIN_VAL = {1'b1, {(WIDTH-1){1'b0}}};

    logic [WIDTH-1:0] neg;
    logic [WIDTH-1:0] iso;

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////

    // invert and add one
    assign neg = ~operand_i + WIDTH'(1);
    // x & -x leaves the lowest set bit
    assign iso = operand_i & neg;

    // one cycle, held while en_i is low
    always_ff @(posedge clk) begin
        if (rst_i) begin
            neg_rsp_o <= '0;
            iso_rsp_o <= '0;
        end else if (en_i) begin
            neg_rsp_o.result <= DW'(neg);
            // negation overflows only at the sign-bit value
            neg_rsp_o.flag   <= (operand_i == MIN_VAL);
            iso_rsp_o.result <= DW'(iso);
            iso_rsp_o.flag   <= |operand_i;
        end
    end

endmodule: bit_isolate

// ==== hdl/onehot_index.sv ====
`timescale 1ns/1ps

module onehot_index #(
    parameter int unsigned WIDTH = 32
)(
    // system signals
    input  logic                 clk,
    input  logic                 rst_i,
    // stage enable from the controller
    input  logic                 en_i,
    // operand, expected one-hot
    input  logic [WIDTH-1:0]     operand_i,
    // registered index and one-hot flag
    output bitops_bus_pkg::rsp_t oh_rsp_o
);

    ////////////////////////////////////////
    // local signals
    ////////////////////////////////////////

    localparam int unsigned DW    = bitops_bus_pkg::DATA_W;
    localparam int unsigned IDX_W = bitops_op_pkg::idx_width(WIDTH);

    // bit i of the mask is bit k of the number i
    // k=0 gives 1010..., k=1 gives 1100..., and so on
    function automatic logic [WIDTH-1:0] pos_mask(input int unsigned k);
        logic [WIDTH-1:0] m;
        for (int unsigned i = 0; i < WIDTH; i++) begin
            m[i] = ((i >> k) & 1) != 0;
        end
        return m;
    endfunction

    logic [IDX_W-1:0] idx;
    logic [WIDTH-1:0] neg;
    logic             is_onehot;
    logic [WIDTH-1:0] operand_q;

    ////////////////////////////////////////
    // logarithm by masks
    ////////////////////////////////////////

    // with one bit set, each index bit is just an OR under its mask
    for (genvar k = 0; k < IDX_W; k++) begin : g_idx
        assign idx[k] = |(operand_i & pos_mask(k));
    end

    // one-hot when nonzero and equal to its own lowest set bit
    assign neg       = ~operand_i + WIDTH'(1);
    assign is_onehot = (operand_i != '0) && (operand_i == (operand_i & neg));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            oh_rsp_o <= '0;
        end else if (en_i) begin
            // zero result for anything not one-hot
            oh_rsp_o.result <= is_onehot ? DW'(idx) : '0;
            oh_rsp_o.flag   <= is_onehot;
        end
    end

    // operand as seen by the registered result
    always_ff @(posedge clk) begin
        if (en_i) begin
            operand_q <= operand_i;
        end
    end

    // a flagged index must land on the bit that was set
    a_idx_on_set_bit: assert property (@(posedge clk) disable iff (rst_i)
        oh_rsp_o.flag |-> operand_q[oh_rsp_o.result[IDX_W-1:0]])
        else $error("onehot_index: flagged index points at a clear bit");

endmodule: onehot_index

// ==== hdl/prio_enc.sv ====
`timescale 1ns/1ps

module prio_enc #(
    parameter int unsigned WIDTH = 32
)(
    // system signals
    input  logic                 clk,
    input  logic                 rst_i,
    // stage enable from the controller
    input  logic                 en_i,
    // request vector, bit 0 wins
    input  logic [WIDTH-1:0]     operand_i,
    // registered lowest index and any-set flag
    output bitops_bus_pkg::rsp_t pe_rsp_o
);

    ////////////////////////////////////////
    // local signals
    ////////////////////////////////////////

    localparam int unsigned DW    = bitops_bus_pkg::DATA_W;
    localparam int unsigned IDX_W = bitops_op_pkg::idx_width(WIDTH);

    logic             any_set;
    logic [IDX_W-1:0] low_idx;

    ////////////////////////////////////////
    // reduction tree
    ////////////////////////////////////////

    // level l holds WIDTH>>l nodes, each a valid and the lowest index below it
    // pairs merge with the lower half taking priority
    for (genvar l = 0; l <= IDX_W; l++) begin : g_lvl
        localparam int unsigned N = WIDTH >> l;
        logic [N-1:0]     v;
        logic [IDX_W-1:0] idx [N];
        if (l == 0) begin : g_leaf
            // leaves are the operand bits, index is the bit position
            for (genvar i = 0; i < N; i++) begin : g_bit
                assign v[i]   = operand_i[i];
                assign idx[i] = IDX_W'(i);
            end
        end else begin : g_pair
            for (genvar i = 0; i < N; i++) begin : g_node
                assign v[i]   = g_lvl[l-1].v[2*i] | g_lvl[l-1].v[2*i+1];
                assign idx[i] = g_lvl[l-1].v[2*i] ? g_lvl[l-1].idx[2*i]
                                                  : g_lvl[l-1].idx[2*i+1];
            end
        end
    end

    // root of the tree
    assign any_set = g_lvl[IDX_W].v[0];
    assign low_idx = g_lvl[IDX_W].idx[0];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pe_rsp_o <= '0;
        end else if (en_i) begin
            // root index is meaningless for a zero operand
            pe_rsp_o.result <= any_set ? DW'(low_idx) : '0;
            pe_rsp_o.flag   <= any_set;
        end
    end

endmodule: prio_enc

// ==== hdl/bitops_ctrl.sv ====
`timescale 1ns/1ps

module bitops_ctrl (
    // system signals
    input  logic                              clk,
    input  logic                              rst_i,
    // request port
    input  logic                              req_valid_i,
    output logic                              req_ready_o,
    input  bitops_bus_pkg::req_t              req_i,
    // response port
    output logic                              rsp_valid_o,
    input  logic                              rsp_ready_i,
    output bitops_bus_pkg::rsp_t              rsp_o,
    // datapath control
    output logic                              en_o,
    output logic [bitops_bus_pkg::DATA_W-1:0] operand_o,
    // datapath results one cycle after en_o
    input  bitops_bus_pkg::rsp_t              neg_rsp_i,
    input  bitops_bus_pkg::rsp_t              iso_rsp_i,
    input  bitops_bus_pkg::rsp_t              oh_rsp_i,
    input  bitops_bus_pkg::rsp_t              pe_rsp_i
);

    ////////////////////////////////////////
    // local signals
    ////////////////////////////////////////

    // stage 1 tracks what the datapath registers hold
    logic                 s1_valid;
    bitops_op_pkg::op_e   s1_op;
    // result picked by the stage-1 opcode
    bitops_bus_pkg::rsp_t sel_rsp;

    ////////////////////////////////////////
    // handshake and enable
    ////////////////////////////////////////

    // whole pipe moves unless the output is full and not taken
    assign en_o        = !rsp_valid_o || rsp_ready_i;
    assign req_ready_o = en_o;
    // operand goes straight to the datapath
    // captured there on en_o
    assign operand_o   = req_i.operand;

    ////////////////////////////////////////
    // stage 1
    ////////////////////////////////////////

    // valid and op run beside the datapath registers
    always_ff @(posedge clk) begin
        if (rst_i) begin
            s1_valid <= 1'b0;
            s1_op    <= bitops_op_pkg::OP_NEG;
        end else if (en_o) begin
            s1_valid <= req_valid_i;
            s1_op    <= req_i.op;
        end
    end

    ////////////////////////////////////////
    // result select and output stage
    ////////////////////////////////////////

    always_comb begin
        case (s1_op)
            bitops_op_pkg::OP_NEG:        sel_rsp = neg_rsp_i;
            bitops_op_pkg::OP_ISO_ONE:    sel_rsp = iso_rsp_i;
            bitops_op_pkg::OP_ONEHOT_IDX: sel_rsp = oh_rsp_i;
            bitops_op_pkg::OP_PRIO_IDX:   sel_rsp = pe_rsp_i;
            default:                      sel_rsp = neg_rsp_i;
        endcase
    end

    // output valid
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rsp_valid_o <= 1'b0;
        end else if (en_o) begin
            rsp_valid_o <= s1_valid;
        end
    end

    // output payload frozen while stalled
    always_ff @(posedge clk) begin
        if (en_o) begin
            rsp_o <= sel_rsp;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // a stalled response holds until taken
    a_rsp_hold: assert property (@(posedge clk) disable iff (rst_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
        else $error("bitops_ctrl: response changed while stalled");

    // a request offered to an empty output stage lands in stage 1
    a_ready_when_empty: assert property (@(posedge clk) disable iff (rst_i)
        !rsp_valid_o && req_valid_i |=> s1_valid)
        else $error("bitops_ctrl: request blocked with empty output stage");

endmodule: bitops_ctrl

// ==== hdl/bitops_top.sv ====
`timescale 1ns/1ps

module bitops_top (
    // system signals
    input  logic                 clk,
    input  logic                 rst_i,
    // request port
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  bitops_bus_pkg::req_t req_i,
    // response port
    output logic                 rsp_valid_o,
    input  logic                 rsp_ready_i,
    output bitops_bus_pkg::rsp_t rsp_o
);

    ////////////////////////////////////////
    // local signals
    ////////////////////////////////////////

    // datapath width follows the bus
    localparam int unsigned WIDTH = bitops_bus_pkg::DATA_W;

    logic                 en;
    logic [WIDTH-1:0]     operand;
    bitops_bus_pkg::rsp_t neg_rsp;
    bitops_bus_pkg::rsp_t iso_rsp;
    bitops_bus_pkg::rsp_t oh_rsp;
    bitops_bus_pkg::rsp_t pe_rsp;

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    bitops_ctrl u_ctrl (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o),
        .en_o        (en),
        .operand_o   (operand),
        .neg_rsp_i   (neg_rsp),
        .iso_rsp_i   (iso_rsp),
        .oh_rsp_i    (oh_rsp),
        .pe_rsp_i    (pe_rsp)
    );

    ////////////////////////////////////////
    // datapath blocks
    ////////////////////////////////////////

    // negate and rightmost-bit isolate share one negation
    bit_isolate #(
        .WIDTH (WIDTH)
    ) u_isolate (
        .clk       (clk),
        .rst_i     (rst_i),
        .en_i      (en),
        .operand_i (operand),
        .neg_rsp_o (neg_rsp),
        .iso_rsp_o (iso_rsp)
    );

    onehot_index #(
        .WIDTH (WIDTH)
    ) u_onehot (
        .clk       (clk),
        .rst_i     (rst_i),
        .en_i      (en),
        .operand_i (operand),
        .oh_rsp_o  (oh_rsp)
    );

    prio_enc #(
        .WIDTH (WIDTH)
    ) u_prio (
        .clk       (clk),
        .rst_i     (rst_i),
        .en_i      (en),
        .operand_i (operand),
        .pe_rsp_o  (pe_rsp)
    );

endmodule: bitops_top

// ==== dv/bitops_clkgen.sv ====
`timescale 1ns/1ps

module bitops_clkgen #(
    // half of the 40 ns period
    parameter int HALF_NS    = 20,
    parameter int RST_CYCLES = 10
)(
    output logic clk_o,
    output logic rst_o
);

    // free-running clock, low at time zero
    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_NS) clk_o = ~clk_o;
        end
    end

    // reset high from time zero, dropped just past the last reset edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_o = 1'b0;
    end

endmodule: bitops_clkgen

// ==== dv/bitops_tb.sv ====
`timescale 1ns/1ps

module bitops_tb;

    ////////////////////////////////////////
    // types and signals
    ////////////////////////////////////////

    localparam int DW      = bitops_bus_pkg::DATA_W;
    // cycles any single wait may take
    localparam int TIMEOUT = 100;

    // directed entry, expected result and flag worked out by hand
    typedef struct packed {
        bitops_op_pkg::op_e op;
        logic [DW-1:0]      operand;
        logic [DW-1:0]      result;
        logic               flag;
    } vec_t;

    logic                 clk;
    logic                 rst_i;
    logic                 req_valid_i;
    logic                 req_ready_o;
    bitops_bus_pkg::req_t req_i;
    logic                 rsp_valid_o;
    logic                 rsp_ready_i;
    bitops_bus_pkg::rsp_t rsp_o;

    // expected response travels beside req_i
    bitops_bus_pkg::rsp_t exp_rsp;
    bitops_bus_pkg::rsp_t exp_q [$];
    // acceptance cycle of each outstanding request
    int                   acc_q [$];
    bitops_bus_pkg::rsp_t held_rsp;
    logic                 stalled = 1'b0;
    logic                 lat_chk;
    logic                 bp_en;
    integer               seed;
    int                   cyc     = 0;
    int                   errors  = 0;
    int                   checked = 0;

    vec_t vectors [24] = '{
        '{bitops_op_pkg::OP_NEG,        32'h0000_0000, 32'h0000_0000, 1'b0},
        '{bitops_op_pkg::OP_NEG,        32'h0000_0001, 32'hffff_ffff, 1'b0},
        '{bitops_op_pkg::OP_NEG,        32'h0000_0020, 32'hffff_ffe0, 1'b0},
        '{bitops_op_pkg::OP_NEG,        32'h8000_0000, 32'h8000_0000, 1'b1},
        '{bitops_op_pkg::OP_NEG,        32'hffff_ffff, 32'h0000_0001, 1'b0},
        '{bitops_op_pkg::OP_ISO_ONE,    32'h0000_0000, 32'h0000_0000, 1'b0},
        '{bitops_op_pkg::OP_ISO_ONE,    32'h0000_0001, 32'h0000_0001, 1'b1},
        '{bitops_op_pkg::OP_ISO_ONE,    32'h0000_0020, 32'h0000_0020, 1'b1},
        '{bitops_op_pkg::OP_ISO_ONE,    32'h8000_0000, 32'h8000_0000, 1'b1},
        '{bitops_op_pkg::OP_ISO_ONE,    32'hffff_ffff, 32'h0000_0001, 1'b1},
        '{bitops_op_pkg::OP_ONEHOT_IDX, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{bitops_op_pkg::OP_ONEHOT_IDX, 32'h0000_0001, 32'h0000_0000, 1'b1},
        '{bitops_op_pkg::OP_ONEHOT_IDX, 32'h0000_0020, 32'h0000_0005, 1'b1},
        '{bitops_op_pkg::OP_ONEHOT_IDX, 32'h8000_0000, 32'h0000_001f, 1'b1},
        '{bitops_op_pkg::OP_ONEHOT_IDX, 32'hffff_ffff, 32'h0000_0000, 1'b0},
        '{bitops_op_pkg::OP_ONEHOT_IDX, 32'h0000_0021, 32'h0000_0000, 1'b0},
        '{bitops_op_pkg::OP_ONEHOT_IDX, 32'h8000_0100, 32'h0000_0000, 1'b0},
        '{bitops_op_pkg::OP_PRIO_IDX,   32'h0000_0000, 32'h0000_0000, 1'b0},
        '{bitops_op_pkg::OP_PRIO_IDX,   32'h0000_0001, 32'h0000_0000, 1'b1},
        '{bitops_op_pkg::OP_PRIO_IDX,   32'h0000_0020, 32'h0000_0005, 1'b1},
        '{bitops_op_pkg::OP_PRIO_IDX,   32'h8000_0000, 32'h0000_001f, 1'b1},
        '{bitops_op_pkg::OP_PRIO_IDX,   32'hffff_ffff, 32'h0000_0000, 1'b1},
        '{bitops_op_pkg::OP_PRIO_IDX,   32'h0000_0021, 32'h0000_0000, 1'b1},
        '{bitops_op_pkg::OP_PRIO_IDX,   32'h8000_0100, 32'h0000_0008, 1'b1}
    };

    bitops_clkgen u_clkgen (
        .clk_o (clk),
        .rst_o (rst_i)
    );

    bitops_top u_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

    ////////////////////////////////////////
    // reference model and helpers
    ////////////////////////////////////////

    function automatic bitops_bus_pkg::rsp_t model(input bitops_op_pkg::op_e op,
                                                   input logic [DW-1:0] x);
        int            low;
        logic [DW-1:0] res;
        logic          flg;
        low = -1;
        // scan downward so the last hit is the lowest set bit
        for (int i = DW - 1; i >= 0; i--) begin
            if (x[i]) begin
                low = i;
            end
        end
        // priority index by default
        flg = (low >= 0);
        res = flg ? DW'(low) : '0;
        if (op == bitops_op_pkg::OP_NEG) begin
            res = DW'(0) - x;
            flg = (x == (DW'(1) << (DW - 1)));
        end else if (op == bitops_op_pkg::OP_ISO_ONE) begin
            res = flg ? (DW'(1) << low) : '0;
        end else if (op == bitops_op_pkg::OP_ONEHOT_IDX && $countones(x) != 1) begin
            res = '0;
            flg = 1'b0;
        end
        return {res, flg};
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // hold one request until taken, ready flips each cycle under back-pressure
    task automatic send(input bitops_bus_pkg::req_t req, input bitops_bus_pkg::rsp_t exp,
                        output int waited);
        logic taken;
        req_valid_i = 1'b1;
        req_i       = req;
        exp_rsp     = exp;
        waited      = 0;
        taken       = 1'b0;
        while (!taken && waited < TIMEOUT) begin
            @(posedge clk);
            taken = req_ready_o;
            waited++;
            #2;
            if (bp_en) begin
                rsp_ready_i = 1'($random(seed));
            end
        end
        req_valid_i = 1'b0;
        if (!taken) begin
            errors++;
            $display("timeout: request with opcode %0d was never accepted", req.op);
        end
    endtask

    // wait until every accepted request has been answered
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("timeout: %0d responses never arrived", exp_q.size());
        end
        @(posedge clk);
        #2;
    endtask

    // n random requests back to back, optionally with random ready
    task automatic random_phase(input int n, input logic bp);
        bitops_bus_pkg::req_t req;
        int                   waited;
        bp_en   = bp;
        lat_chk = !bp;
        for (int i = 0; i < n; i++) begin
            req.op      = bitops_op_pkg::op_e'(2'($random(seed)));
            req.operand = $random(seed);
            // roughly one in four operands is one-hot
            if (($random(seed) & 3) == 0) begin
                req.operand = DW'(1) << ($random(seed) & 31);
            end
            send(req, model(req.op, req.operand), waited);
            // free-flowing pipe takes one request per cycle
            if (!bp) begin
                check("accept wait", waited, 1);
            end
        end
        bp_en       = 1'b0;
        rsp_ready_i = 1'b1;
        drain();
    endtask

    ////////////////////////////////////////
    // response monitor
    ////////////////////////////////////////

    always @(posedge clk) begin
        cyc++;
        if (!rst_i) begin
            // stalled response must not move
            if (stalled) begin
                check("rsp_valid_o", rsp_valid_o, 1'b1);
                check("rsp_o", rsp_o, held_rsp);
            end
            if (rsp_valid_o && !rsp_ready_i) begin
                check("req_ready_o", req_ready_o, 1'b0);
            end
            if (rsp_valid_o && rsp_ready_i) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("response arrived with no request outstanding");
                end else begin
                    check("rsp_o.result", rsp_o.result, exp_q[0].result);
                    check("rsp_o.flag", rsp_o.flag, exp_q[0].flag);
                    // accepted at N, taken at N+2 when nothing stalls
                    if (lat_chk) begin
                        check("latency", cyc - acc_q[0], 2);
                    end
                    void'(exp_q.pop_front());
                    void'(acc_q.pop_front());
                    checked++;
                end
            end
            if (req_valid_i && req_ready_o) begin
                exp_q.push_back(exp_rsp);
                acc_q.push_back(cyc);
            end
        end
        stalled  = !rst_i && rsp_valid_o && !rsp_ready_i;
        held_rsp = rsp_o;
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        int waited;
        seed        = 32'hecdd;
        req_valid_i = 1'b0;
        req_i       = '0;
        rsp_ready_i = 1'b1;
        exp_rsp     = '0;
        bp_en       = 1'b0;
        lat_chk     = 1'b1;

        waited = 0;
        while (rst_i !== 1'b0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rst_i !== 1'b0) begin
            errors++;
            $display("timeout: reset was never released");
        end
        #2;
        check("rsp_valid_o", rsp_valid_o, 1'b0);
        check("req_ready_o", req_ready_o, 1'b1);

        // directed table
        foreach (vectors[i]) begin
            send({vectors[i].op, vectors[i].operand},
                 {vectors[i].result, vectors[i].flag}, waited);
        end
        drain();

        // lone request on an idle pipe
        send({bitops_op_pkg::OP_PRIO_IDX, DW'(32'h0000_0100)}, {DW'(8), 1'b1}, waited);
        drain();

        random_phase(200, 1'b0);
        random_phase(200, 1'b1);
        check("expected queue size", exp_q.size(), 0);

        $display("errors: %0d, responses checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule: bitops_tb

// ==== flist.f ====
hdl/bitops_op_pkg.sv
hdl/bitops_bus_pkg.sv
hdl/bit_isolate.sv
hdl/onehot_index.sv
hdl/prio_enc.sv
hdl/bitops_ctrl.sv
hdl/bitops_top.sv
dv/bitops_clkgen.sv
dv/bitops_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the bitops testbench with Verilator, run it, then look for the pass line
verilator --binary --timing --assert -Wno-fatal --top-module bitops_tb \
    -f flist.f -o bitops_sim > build.log 2>&1 \
    && ./obj_dir/bitops_sim > sim.log 2>&1 \
    && grep -qx 'All tests passed!' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
